// File: alu_pkg.sv
/*
 * ALU package
 * Data widths, operator codes and result-select codes shared by
 * the integer and LDPC datapaths
 */

package alu_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [7:0]      byte_t;
  typedef logic [4:0]      alu_op_t;
  typedef logic [1:0]      res_sel_t;

  // ----------------------------------------------------------
  // Operator codes
  // ----------------------------------------------------------
  localparam alu_op_t OP_ADD              = 5'd0;
  localparam alu_op_t OP_SUB              = 5'd1;
  localparam alu_op_t OP_ADDW             = 5'd2;
  localparam alu_op_t OP_SUBW             = 5'd3;
  localparam alu_op_t OP_AND              = 5'd4;
  localparam alu_op_t OP_OR               = 5'd5;
  localparam alu_op_t OP_XOR              = 5'd6;
  localparam alu_op_t OP_SLL              = 5'd7;
  localparam alu_op_t OP_SRL              = 5'd8;
  localparam alu_op_t OP_SRA              = 5'd9;
  localparam alu_op_t OP_SLLW             = 5'd10;
  localparam alu_op_t OP_SRLW             = 5'd11;
  localparam alu_op_t OP_SRAW             = 5'd12;
  localparam alu_op_t OP_SLTS             = 5'd13;
  localparam alu_op_t OP_SLTU             = 5'd14;
  // Branch compares
  localparam alu_op_t OP_EQ               = 5'd15;
  localparam alu_op_t OP_NE               = 5'd16;
  localparam alu_op_t OP_LTS              = 5'd17;
  localparam alu_op_t OP_LTU              = 5'd18;
  localparam alu_op_t OP_GES              = 5'd19;
  localparam alu_op_t OP_GEU              = 5'd20;
  // LDPC min-sum helpers on the low int8 operand bytes
  localparam alu_op_t OP_LDPC_MIN         = 5'd21;
  localparam alu_op_t OP_LDPC_ABS         = 5'd22;
  localparam alu_op_t OP_LDPC_ADD_SAT     = 5'd23;
  localparam alu_op_t OP_LDPC_SUB_SAT     = 5'd24;
  localparam alu_op_t OP_LDPC_MINMAX      = 5'd25;
  localparam alu_op_t OP_LDPC_MIN_SORTING = 5'd26;
  localparam alu_op_t OP_LDPC_RSIGN       = 5'd27;

  // ----------------------------------------------------------
  // Result select and LDPC limit
  // ----------------------------------------------------------
  localparam res_sel_t SEL_ADD   = 2'd0;
  localparam res_sel_t SEL_LOGIC = 2'd1;
  localparam res_sel_t SEL_SHIFT = 2'd2;
  localparam res_sel_t SEL_CMP   = 2'd3;

  // Symmetric clamp so -128 never leaves the LDPC unit
  localparam int LDPC_SAT_MAX = 127;

endpackage

// File: alu_ctrl_if.sv
/*
 * ALU control interface
 * Decoded control fields from the decoder to the execute and result stages
 */

`timescale 1ns/1ps

interface alu_ctrl_if import alu_pkg::*; ();

  logic     negate_b;
  logic     signed_cmp;
  logic     shift_left;
  logic     shift_arith;
  logic     word_op;
  res_sel_t res_sel;
  logic     ldpc_sel;
  logic     branch_op;
  logic     is_known;

  modport decoder (
    output negate_b, signed_cmp, shift_left, shift_arith, word_op,
    output res_sel, ldpc_sel, branch_op, is_known
  );

  modport exec (
    input negate_b, signed_cmp, shift_left, shift_arith
  );

  modport result (
    input res_sel, ldpc_sel, word_op, branch_op, is_known
  );

endinterface

// File: alu_decoder.sv
/*
 * ALU decoder
 * Combinational table from operator code to datapath control fields
 */

`timescale 1ns/1ps

module alu_decoder import alu_pkg::*; (
  input  alu_op_t            op_i,
  alu_ctrl_if.decoder        ctrl
);

  always_comb begin
    ctrl.negate_b    = 1'b0;
    ctrl.signed_cmp  = 1'b0;
    ctrl.shift_left  = 1'b0;
    ctrl.shift_arith = 1'b0;
    ctrl.word_op     = 1'b0;
    ctrl.res_sel     = SEL_ADD;
    ctrl.ldpc_sel    = 1'b0;
    ctrl.branch_op   = 1'b0;
    ctrl.is_known    = 1'b1;

    case (op_i)
      // Plain add needs nothing beyond the defaults
      OP_ADD: ;
      OP_SUB: ctrl.negate_b = 1'b1;
      OP_ADDW: ctrl.word_op = 1'b1;
      OP_SUBW: begin
        ctrl.negate_b = 1'b1;
        ctrl.word_op  = 1'b1;
      end

      // Logic ops borrow the shift bits as sub-select
      // none = AND, shift_left = OR, shift_arith = XOR
      OP_AND: ctrl.res_sel = SEL_LOGIC;
      OP_OR: begin
        ctrl.res_sel    = SEL_LOGIC;
        ctrl.shift_left = 1'b1;
      end
      OP_XOR: begin
        ctrl.res_sel     = SEL_LOGIC;
        ctrl.shift_arith = 1'b1;
      end

      // Shifts
      OP_SLL, OP_SLLW: begin
        ctrl.res_sel    = SEL_SHIFT;
        ctrl.shift_left = 1'b1;
        ctrl.word_op    = (op_i == OP_SLLW);
      end
      OP_SRL, OP_SRLW: begin
        ctrl.res_sel = SEL_SHIFT;
        ctrl.word_op = (op_i == OP_SRLW);
      end
      OP_SRA, OP_SRAW: begin
        ctrl.res_sel     = SEL_SHIFT;
        ctrl.shift_arith = 1'b1;
        ctrl.word_op     = (op_i == OP_SRAW);
      end

      // Set-less-than
      OP_SLTS, OP_SLTU: begin
        ctrl.res_sel    = SEL_CMP;
        ctrl.negate_b   = 1'b1;
        ctrl.signed_cmp = (op_i == OP_SLTS);
      end

      // Branch compares go through the adder for the zero flag
      OP_EQ, OP_NE, OP_LTS, OP_LTU, OP_GES, OP_GEU: begin
        ctrl.negate_b   = 1'b1;
        ctrl.branch_op  = 1'b1;
        ctrl.signed_cmp = (op_i == OP_LTS) || (op_i == OP_GES);
      end

      OP_LDPC_MIN, OP_LDPC_ABS, OP_LDPC_ADD_SAT, OP_LDPC_SUB_SAT,
      OP_LDPC_MINMAX, OP_LDPC_MIN_SORTING, OP_LDPC_RSIGN: begin
        ctrl.ldpc_sel = 1'b1;
      end

      default: ctrl.is_known = 1'b0;
    endcase
  end

endmodule

// File: alu_int_unit.sv
/*
 * Integer execute unit
 * Shared add/subtract, logic ops, barrel shifter and comparator
 */

`timescale 1ns/1ps

module alu_int_unit import alu_pkg::*; (
  input  xlen_t           operand_a_i,
  input  xlen_t           operand_b_i,
  alu_ctrl_if.exec        ctrl,
  output xlen_t           add_o,
  output xlen_t           logic_o,
  output xlen_t           shift_o,
  output xlen_t           shift_w_o,
  output logic            less_o,
  output logic            zero_o
);

  xlen_t           adder_b;
  xlen_t           sum;

  xlen_t           a_rev;
  logic [31:0]     a_rev32;
  xlen_t           shift_in;
  logic [31:0]     shift_in32;
  logic [XLEN:0]   shr_res;
  logic [32:0]     shr_res32;
  xlen_t           shr_rev;
  logic [31:0]     shr_rev32;

  // ----------------------------------------------------------
  // Adder
  // ----------------------------------------------------------
  // Two's complement subtract as a + ~b + 1
  assign adder_b = ctrl.negate_b ? ~operand_b_i : operand_b_i;
  assign sum     = operand_a_i + adder_b + {{(XLEN-1){1'b0}}, ctrl.negate_b};
  assign add_o   = sum;
  assign zero_o  = ~|sum;

  // ----------------------------------------------------------
  // Logic
  // ----------------------------------------------------------
  always_comb begin
    if (ctrl.shift_arith) begin
      logic_o = operand_a_i ^ operand_b_i;
    end else if (ctrl.shift_left) begin
      logic_o = operand_a_i | operand_b_i;
    end else begin
      logic_o = operand_a_i & operand_b_i;
    end
  end

  // ----------------------------------------------------------
  // Shifter
  // ----------------------------------------------------------
  // Left shift = reverse, shift right, reverse back
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      a_rev[i] = operand_a_i[XLEN-1-i];
    end
    for (int i = 0; i < 32; i++) begin
      a_rev32[i] = operand_a_i[31-i];
    end
  end

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      shr_rev[i] = shr_res[XLEN-1-i];
    end
    for (int i = 0; i < 32; i++) begin
      shr_rev32[i] = shr_res32[31-i];
    end
  end

  assign shift_in   = ctrl.shift_left ? a_rev : operand_a_i;
  assign shift_in32 = ctrl.shift_left ? a_rev32 : operand_a_i[31:0];

  // Extra top bit carries the fill value for arithmetic shifts
  assign shr_res   = $unsigned($signed({ctrl.shift_arith & shift_in[XLEN-1], shift_in})
                               >>> operand_b_i[5:0]);
  assign shr_res32 = $unsigned($signed({ctrl.shift_arith & shift_in32[31], shift_in32})
                               >>> operand_b_i[4:0]);

  assign shift_o   = ctrl.shift_left ? shr_rev : shr_res[XLEN-1:0];
  assign shift_w_o = {32'b0, (ctrl.shift_left ? shr_rev32 : shr_res32[31:0])};

  // ----------------------------------------------------------
  // Comparator
  // ----------------------------------------------------------
  assign less_o = $signed({ctrl.signed_cmp & operand_a_i[XLEN-1], operand_a_i}) <
                  $signed({ctrl.signed_cmp & operand_b_i[XLEN-1], operand_b_i});

endmodule

// File: alu_ldpc_unit.sv
/*
 * LDPC execute unit
 * Saturating int8 arithmetic and min-sum helpers on the low operand bytes
 */

`timescale 1ns/1ps

module alu_ldpc_unit import alu_pkg::*; (
  input  alu_op_t op_i,
  input  xlen_t   operand_a_i,
  input  xlen_t   operand_b_i,
  input  xlen_t   operand_c_i,
  output byte_t   ldpc_o
);

  logic signed [8:0] a9;
  logic signed [8:0] b9;
  logic signed [8:0] c9;
  logic signed [8:0] sum9;
  logic signed [8:0] diff9;
  logic signed [8:0] max_ab;
  logic signed [8:0] pre_sat;

  // Sign-extend the low bytes one bit for overflow headroom
  assign a9 = {operand_a_i[7], operand_a_i[7:0]};
  assign b9 = {operand_b_i[7], operand_b_i[7:0]};
  assign c9 = {operand_c_i[7], operand_c_i[7:0]};

  assign sum9   = a9 + b9;
  assign diff9  = a9 - b9;
  assign max_ab = (a9 >= b9) ? a9 : b9;

  // ----------------------------------------------------------
  // Operation select before saturation
  // ----------------------------------------------------------
  always_comb begin
    case (op_i)
      OP_LDPC_MIN:         pre_sat = (a9 < b9) ? a9 : b9;
      OP_LDPC_ABS:         pre_sat = a9[8] ? -a9 : a9;
      OP_LDPC_ADD_SAT:     pre_sat = sum9;
      OP_LDPC_SUB_SAT:     pre_sat = diff9;
      OP_LDPC_MINMAX:      pre_sat = (c9 < max_ab) ? c9 : max_ab;
      // Second minimum replaces a duplicate first minimum
      OP_LDPC_MIN_SORTING: pre_sat = (a9 == b9) ? c9 : a9;
      // Flip the message sign when a and b disagree
      OP_LDPC_RSIGN:       pre_sat = (a9[8] ^ b9[8]) ? -c9 : c9;
      default:             pre_sat = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Symmetric clamp
  // ----------------------------------------------------------
  always_comb begin
    if (pre_sat > LDPC_SAT_MAX) begin
      ldpc_o = byte_t'(LDPC_SAT_MAX);
    end else if (pre_sat < -LDPC_SAT_MAX) begin
      ldpc_o = byte_t'(-LDPC_SAT_MAX);
    end else begin
      ldpc_o = pre_sat[7:0];
    end
  end

endmodule

// File: alu_result_stage.sv
/*
 * ALU result stage
 * Result mux, word sign extension, branch outcome and output registers
 */

`timescale 1ns/1ps

module alu_result_stage import alu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  alu_op_t           op_i,
  input  xlen_t             add_i,
  input  xlen_t             logic_i,
  input  xlen_t             shift_i,
  input  xlen_t             shift_w_i,
  input  logic              less_i,
  input  logic              zero_i,
  input  byte_t             ldpc_i,
  alu_ctrl_if.result        ctrl,
  output logic              valid_o,
  output xlen_t             result_o,
  output logic              branch_taken_o
);

  xlen_t sel_res;
  xlen_t word_res;
  xlen_t result_d;
  logic  branch_d;

  always_comb begin
    sel_res = '0;
    case (ctrl.res_sel)
      SEL_ADD:   sel_res = add_i;
      SEL_LOGIC: sel_res = logic_i;
      SEL_SHIFT: sel_res = ctrl.word_op ? shift_w_i : shift_i;
      SEL_CMP:   sel_res = {{(XLEN-1){1'b0}}, less_i};
    endcase
  end

  // W forms keep the low word and sign-extend bit 31
  assign word_res = ctrl.word_op ? {{(XLEN-32){sel_res[31]}}, sel_res[31:0]} : sel_res;

  always_comb begin
    if (!ctrl.is_known || ctrl.branch_op) begin
      result_d = '0;
    end else if (ctrl.ldpc_sel) begin
      result_d = {{(XLEN-8){1'b0}}, ldpc_i};
    end else begin
      result_d = word_res;
    end
  end

  // Branch condition from the adder zero flag and comparator
  always_comb begin
    case (op_i)
      OP_EQ:          branch_d = zero_i;
      OP_NE:          branch_d = ~zero_i;
      OP_LTS, OP_LTU: branch_d = less_i;
      OP_GES, OP_GEU: branch_d = ~less_i;
      default:        branch_d = 1'b0;
    endcase
  end

  // ----------------------------------------------------------
  // Output registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o        <= 1'b0;
      result_o       <= '0;
      branch_taken_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      // Hold last result across idle cycles
      if (valid_i) begin
        result_o       <= result_d;
        branch_taken_o <= branch_d;
      end
    end
  end

endmodule

// File: alu_top.sv
/*
 * ALU top level
 * Integer and int8 LDPC ALU with a single registered result stage
 */

`timescale 1ns/1ps

module alu_top import alu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    valid_i,
  input  alu_op_t op_i,
  input  xlen_t   operand_a_i,
  input  xlen_t   operand_b_i,
  input  xlen_t   operand_c_i,
  output logic    valid_o,
  output xlen_t   result_o,
  output logic    branch_taken_o
);

  xlen_t add_res;
  xlen_t logic_res;
  xlen_t shift_res;
  xlen_t shift_w_res;
  logic  less;
  logic  zero;
  byte_t ldpc_res;

  alu_ctrl_if ctrl_if ();

  alu_decoder u_decoder (
    .op_i (op_i),
    .ctrl (ctrl_if.decoder)
  );

  alu_int_unit u_int_unit (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .ctrl        (ctrl_if.exec),
    .add_o       (add_res),
    .logic_o     (logic_res),
    .shift_o     (shift_res),
    .shift_w_o   (shift_w_res),
    .less_o      (less),
    .zero_o      (zero)
  );

  alu_ldpc_unit u_ldpc_unit (
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .ldpc_o      (ldpc_res)
  );

  alu_result_stage u_result_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (valid_i),
    .op_i           (op_i),
    .add_i          (add_res),
    .logic_i        (logic_res),
    .shift_i        (shift_res),
    .shift_w_i      (shift_w_res),
    .less_i         (less),
    .zero_i         (zero),
    .ldpc_i         (ldpc_res),
    .ctrl           (ctrl_if.result),
    .valid_o        (valid_o),
    .result_o       (result_o),
    .branch_taken_o (branch_taken_o)
  );

endmodule

// File: tb_alu_top.sv
/*
 * ALU testbench
 * Reference model, directed and random stimulus, assertion-based checks
 */

`timescale 1ns/1ps

module tb_alu_top import alu_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int N_DIRECTED = 800;
  localparam int N_RANDOM   = 400;
  // Each operation may be trailed by one idle cycle
  localparam int TIMEOUT_NS = (2 * (N_DIRECTED + N_RANDOM) + 100) * CLK_PERIOD;

  localparam alu_op_t INT_OPS [9] = '{OP_ADD, OP_SUB, OP_ADDW, OP_SUBW, OP_AND, OP_OR,
                                      OP_XOR, OP_SLTS, OP_SLTU};
  localparam alu_op_t SHIFT_OPS [6] = '{OP_SLL, OP_SRL, OP_SRA, OP_SLLW, OP_SRLW, OP_SRAW};
  localparam alu_op_t BRANCH_OPS [6] = '{OP_EQ, OP_NE, OP_LTS, OP_LTU, OP_GES, OP_GEU};
  localparam alu_op_t LDPC_OPS [7] = '{OP_LDPC_MIN, OP_LDPC_ABS, OP_LDPC_ADD_SAT,
                                       OP_LDPC_SUB_SAT, OP_LDPC_MINMAX,
                                       OP_LDPC_MIN_SORTING, OP_LDPC_RSIGN};
  localparam byte_t EDGE_BYTES [6] = '{8'h7f, 8'h81, 8'h80, 8'h00, 8'h01, 8'hff};
  localparam logic [5:0] SHAMTS [5] = '{6'd0, 6'd31, 6'd63, 6'd32, 6'd1};
  // Signed and unsigned orderings disagree on most of these
  localparam xlen_t PAIR_A [5] = '{64'h8000_0000_0000_0000, 64'h1, 64'hffff_ffff_ffff_ffff,
                                   64'h0, 64'h7fff_ffff_ffff_ffff};
  localparam xlen_t PAIR_B [5] = '{64'h1, 64'h8000_0000_0000_0000, 64'h0,
                                   64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000};

  logic          clk_i;
  logic          rst_n_i;
  logic          valid_i;
  alu_op_t       op_i;
  xlen_t         operand_a_i;
  xlen_t         operand_b_i;
  xlen_t         operand_c_i;
  logic          valid_o;
  xlen_t         result_o;
  logic          branch_taken_o;

  integer        seed;
  int            errors  = 0;
  int            issued  = 0;
  int            checked = 0;
  alu_op_t       pending[$];
  logic [XLEN:0] exp_now;
  xlen_t         exp_res_q;
  logic          exp_br_q;
  alu_op_t       exp_op_q;

  alu_top uut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (valid_i),
    .op_i           (op_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .operand_c_i    (operand_c_i),
    .valid_o        (valid_o),
    .result_o       (result_o),
    .branch_taken_o (branch_taken_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Reference model returning {branch, result}
  // ----------------------------------------------------------
  function automatic xlen_t sext_word(input logic [31:0] w);
    sext_word = {{32{w[31]}}, w};
  endfunction

  function automatic logic [XLEN:0] ref_model(input alu_op_t op, input xlen_t a,
                                              input xlen_t b, input xlen_t c);
    xlen_t res;
    logic  br;
    int    sa;
    int    sb;
    int    sc;
    int    r;
    res = '0;
    br  = 1'b0;
    r   = 0;
    sa  = int'($signed(a[7:0]));
    sb  = int'($signed(b[7:0]));
    sc  = int'($signed(c[7:0]));
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_ADDW: res = sext_word(a[31:0] + b[31:0]);
      OP_SUBW: res = sext_word(a[31:0] - b[31:0]);
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_SLL:  res = a << b[5:0];
      OP_SRL:  res = a >> b[5:0];
      OP_SRA:  res = $signed(a) >>> b[5:0];
      OP_SLLW: res = sext_word(a[31:0] << b[4:0]);
      OP_SRLW: res = sext_word(a[31:0] >> b[4:0]);
      OP_SRAW: res = sext_word($signed(a[31:0]) >>> b[4:0]);
      OP_SLTS: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      OP_SLTU: res = (a < b) ? 64'd1 : 64'd0;
      OP_EQ:   br = (a == b);
      OP_NE:   br = (a != b);
      OP_LTS:  br = ($signed(a) < $signed(b));
      OP_LTU:  br = (a < b);
      OP_GES:  br = ($signed(a) >= $signed(b));
      OP_GEU:  br = (a >= b);
      OP_LDPC_MIN:         r = (sa < sb) ? sa : sb;
      OP_LDPC_ABS:         r = (sa < 0) ? -sa : sa;
      OP_LDPC_ADD_SAT:     r = sa + sb;
      OP_LDPC_SUB_SAT:     r = sa - sb;
      OP_LDPC_MINMAX:      r = (sc < ((sa > sb) ? sa : sb)) ? sc : ((sa > sb) ? sa : sb);
      OP_LDPC_MIN_SORTING: r = (sa == sb) ? sc : sa;
      OP_LDPC_RSIGN:       r = ((sa < 0) != (sb < 0)) ? -sc : sc;
      default:             res = '0;
    endcase
    if (op inside {OP_LDPC_MIN, OP_LDPC_ABS, OP_LDPC_ADD_SAT, OP_LDPC_SUB_SAT,
                   OP_LDPC_MINMAX, OP_LDPC_MIN_SORTING, OP_LDPC_RSIGN}) begin
      if (r > LDPC_SAT_MAX) begin
        r = LDPC_SAT_MAX;
      end else if (r < -LDPC_SAT_MAX) begin
        r = -LDPC_SAT_MAX;
      end
      res = {{(XLEN-8){1'b0}}, r[7:0]};
    end
    ref_model = {br, res};
  endfunction

  assign exp_now = ref_model(op_i, operand_a_i, operand_b_i, operand_c_i);

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------
  function automatic xlen_t rand64();
    rand64 = {$random(seed), $random(seed)};
  endfunction

  // Random upper bits that the DUT must ignore
  function automatic xlen_t with_low_byte(input byte_t v);
    xlen_t r;
    r = rand64();
    with_low_byte = {r[XLEN-1:8], v};
  endfunction

  function automatic xlen_t with_shamt(input logic [5:0] amt);
    xlen_t r;
    r = rand64();
    with_shamt = {r[XLEN-1:6], amt};
  endfunction

  task automatic issue(input alu_op_t op, input xlen_t a, input xlen_t b, input xlen_t c);
    @(posedge clk_i);
    valid_i     <= 1'b1;
    op_i        <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    operand_c_i <= c;
    issued++;
  endtask

  // Junk on the operands while valid_i is low
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      valid_i     <= 1'b0;
      op_i        <= alu_op_t'($random(seed));
      operand_a_i <= rand64();
      operand_b_i <= rand64();
      operand_c_i <= rand64();
    end
  endtask

  // ----------------------------------------------------------
  // Tracking and checks
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_n_i && valid_o) begin
      assert (pending.size() > 0)
        else begin
          $display("Error at %0t: valid_o high with no operation pending", $time);
          errors++;
        end
      if (pending.size() > 0) begin
        void'(pending.pop_front());
      end
      checked++;
    end
    if (valid_i) begin
      pending.push_back(op_i);
      exp_op_q  <= op_i;
      exp_res_q <= exp_now[XLEN-1:0];
      exp_br_q  <= exp_now[XLEN];
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_o == $past(valid_i))
    else begin
      $display("FAILED at %0t: valid_o %b does not match valid_i of the previous cycle",
               $time, $sampled(valid_o));
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   valid_o |-> (result_o == exp_res_q && branch_taken_o == exp_br_q))
    else begin
      $display("FAILED at %0t: op %0d gave result %h branch %b, expected %h branch %b",
               $time, $sampled(exp_op_q), $sampled(result_o), $sampled(branch_taken_o),
               $sampled(exp_res_q), $sampled(exp_br_q));
      errors++;
    end

  // Idle cycles hold the last result
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   !valid_o |-> (result_o == $past(result_o) &&
                                 branch_taken_o == $past(branch_taken_o)))
    else begin
      $display("FAILED at %0t: result_o %h changed during an idle cycle",
               $time, $sampled(result_o));
      errors++;
    end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    xlen_t a;
    seed        = 32'h217f_e933;
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    op_i        = OP_ADD;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    assert (valid_o == 1'b0 && result_o == '0 && branch_taken_o == 1'b0)
      else begin
        $display("FAILED at %0t: outputs not cleared by reset", $time);
        errors++;
      end

    // Add, subtract, logic, set-less-than, then word overflow
    repeat (20) begin
      foreach (INT_OPS[k]) issue(INT_OPS[k], rand64(), rand64(), rand64());
    end
    issue(OP_ADDW, 64'h0000_0000_7fff_ffff, 64'h1, '0);
    issue(OP_SUBW, 64'hffff_ffff_8000_0000, 64'h1, '0);
    idle(2);

    foreach (SHIFT_OPS[k]) begin
      foreach (SHAMTS[s]) issue(SHIFT_OPS[k], rand64(), with_shamt(SHAMTS[s]), '0);
      repeat (8) issue(SHIFT_OPS[k], rand64(), rand64(), '0);
    end
    idle(1);

    foreach (BRANCH_OPS[k]) begin
      a = rand64();
      issue(BRANCH_OPS[k], a, a, '0);
      foreach (PAIR_A[p]) issue(BRANCH_OPS[k], PAIR_A[p], PAIR_B[p], '0);
      repeat (4) issue(BRANCH_OPS[k], rand64(), rand64(), '0);
      idle(1);
    end

    // LDPC edge bytes with a equal to b on the diagonal
    foreach (LDPC_OPS[k]) begin
      foreach (EDGE_BYTES[i]) begin
        foreach (EDGE_BYTES[j]) begin
          issue(LDPC_OPS[k], with_low_byte(EDGE_BYTES[i]), with_low_byte(EDGE_BYTES[j]),
                with_low_byte(EDGE_BYTES[(i + j) % 6]));
        end
      end
      repeat (20) issue(LDPC_OPS[k], rand64(), rand64(), rand64());
    end

    // Undefined codes
    for (int k = 28; k < 32; k++) begin
      issue(alu_op_t'(k), rand64(), rand64(), rand64());
      idle(1);
    end

    // Random mix with gaps
    repeat (N_RANDOM) begin
      issue(alu_op_t'($random(seed)), rand64(), rand64(), rand64());
      if ($random(seed) % 4 == 0) begin
        idle(1);
      end
    end
    idle(3);

    assert (pending.size() == 0)
      else begin
        $display("Error: %0d operations never produced valid_o", pending.size());
        errors++;
      end
    $display("Checked %0d of %0d operations, %0d errors", checked, issued, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run was still going after %0d ns", TIMEOUT_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: alu_top.f
alu_pkg.sv
alu_ctrl_if.sv
alu_decoder.sv
alu_int_unit.sv
alu_ldpc_unit.sv
alu_result_stage.sv
alu_top.sv
tb_alu_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_alu_top -f alu_top.f -o sim_alu

./obj_dir/sim_alu | tee sim.log

if grep -q "Test FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
